// File: files.f
+incdir+hdl
hdl/pmtrdt_pkg.sv
hdl/pmtrdt_uop_queue.sv
hdl/pmtrdt_unit.sv
hdl/pmtrdt_rob_port.sv
hdl/pmtrdt_top.sv
dv/pmtrdt_tb.sv

// File: Makefile
TOP = pmtrdt_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "All tests passed!" > /dev/null

clean:
	rm -rf obj_dir

// File: dv/pmtrdt_tb.sv
`timescale 1ns/1ps
`include "pmtrdt_defs.svh"

module pmtrdt_tb import pmtrdt_pkg::*;;

  // latency 1, directed 66, random 60, fill 9
  localparam int NUM_UOPS    = 136;
  localparam int CYCLE_LIMIT = NUM_UOPS * 8 + 200;
  // queue 4 + accept, stage 1, output reg, ROB port main and skid
  localparam int SYS_CAP     = 9;

  logic                          clk;
  logic                          rst_n;
  logic                          push_valid;
  logic                          push_ready;
  logic [`PMTRDT_OP_W-1:0]       push_op;
  logic [`PMTRDT_VLEN-1:0]       push_vs1;
  logic [`PMTRDT_VLEN-1:0]       push_vs2;
  logic [`PMTRDT_NUM_ELEM-1:0]   push_v0;
  logic                          push_vm;
  logic [`PMTRDT_ROB_IDX_W-1:0]  push_rob_idx;
  logic                          result_valid;
  logic                          result_ready;
  pmtrdt_vd_u                    result_vd;
  logic [`PMTRDT_ROB_IDX_W-1:0]  result_rob_idx;

  logic [15:0]                   lfsr_state;
  logic [`PMTRDT_ROB_IDX_W-1:0]  next_rob;
  logic                          random_ready;
  string                         phase;
  int                            in_flight;
  int                            push_count;
  int                            cycle_count;

  // scoreboard, one entry per accepted push
  logic [63:0]                   exp_vd_q [$];
  logic [`PMTRDT_ROB_IDX_W-1:0]  exp_rob_q [$];
  string                         exp_name_q [$];

  pmtrdt_top pmtrdt_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .push_valid     (push_valid),
    .push_ready     (push_ready),
    .push_op        (push_op),
    .push_vs1       (push_vs1),
    .push_vs2       (push_vs2),
    .push_v0        (push_v0),
    .push_vm        (push_vm),
    .push_rob_idx   (push_rob_idx),
    .result_valid   (result_valid),
    .result_ready   (result_ready),
    .result_vd      (result_vd),
    .result_rob_idx (result_rob_idx)
  );

  always #50 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp_vd,
                                 input logic [63:0] act_vd, input int exp_rob,
                                 input int act_rob);
    $display("FAIL %s expected rob_idx %0d vd %h actual rob_idx %0d vd %h",
             name, exp_rob, exp_vd, act_rob, act_vd);
    $display("Test failures found");
    $fatal(1);
  endtask

  // galois lfsr, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // about half the elements equal to vs2 so eq and ne both hit
  function automatic logic [63:0] make_vs1(input logic [63:0] vs2);
    logic [63:0] r;
    for (int i = 0; i < 8; i++)
      r[i*8 +: 8] = rand_bits(1) ? vs2[i*8 +: 8] : 8'(rand_bits(8));
    return r;
  endfunction

  function automatic string op_class(input logic [3:0] op);
    if (op <= `PMTRDT_OP_CMP_LT)
      return "compare";
    else if (op == `PMTRDT_OP_COMPRESS)
      return "compress";
    else
      return "reduction";
  endfunction

  // expected destination straight from the op rules
  function automatic logic [63:0] ref_vd(input logic [3:0] op, input logic [63:0] vs1,
                                         input logic [63:0] vs2, input logic [7:0] v0,
                                         input logic vm);
    logic [7:0]  act;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  acc;
    logic [63:0] r;
    int          slot;
    act  = vm ? 8'hff : v0;
    r    = '0;
    acc  = vs1[7:0];
    slot = 0;
    // inactive elements are skipped entirely
    for (int i = 0; i < 8; i++) begin
      a = vs2[i*8 +: 8];
      b = vs1[i*8 +: 8];
      if (act[i]) begin
        case (op)
          `PMTRDT_OP_CMP_EQ:   r[i] = (a == b);
          `PMTRDT_OP_CMP_NE:   r[i] = (a != b);
          `PMTRDT_OP_CMP_LTU:  r[i] = (a < b);
          `PMTRDT_OP_CMP_LT:   r[i] = ($signed(a) < $signed(b));
          `PMTRDT_OP_RED_SUM:  acc = acc + a;
          `PMTRDT_OP_RED_MAXU: acc = (a > acc) ? a : acc;
          `PMTRDT_OP_RED_MINU: acc = (a < acc) ? a : acc;
          `PMTRDT_OP_RED_AND:  acc = acc & a;
          `PMTRDT_OP_RED_OR:   acc = acc | a;
          `PMTRDT_OP_RED_XOR:  acc = acc ^ a;
          `PMTRDT_OP_COMPRESS: begin
            r[slot*8 +: 8] = a;
            slot++;
          end
          default: ;
        endcase
      end
    end
    // scalar lands in element 0, everything else zero
    if (op_class(op) == "reduction")
      r = {56'd0, acc};
    return r;
  endfunction

  // random ready only in the back-pressure phase
  task automatic drive_ready();
    if (random_ready)
      result_ready = 1'(rand_bits(1));
  endtask

  // called at a falling edge, returns at the falling edge after the push
  task automatic push_uop(input logic [3:0] op, input logic [63:0] vs1,
                          input logic [63:0] vs2, input logic [7:0] v0, input logic vm);
    push_valid   = 1'b1;
    push_op      = op;
    push_vs1     = vs1;
    push_vs2     = vs2;
    push_v0      = v0;
    push_vm      = vm;
    push_rob_idx = next_rob;
    // push_ready only depends on registers, stable from here to the edge
    while (!push_ready) begin
      @(negedge clk);
      drive_ready();
    end
    @(negedge clk);
    drive_ready();
    push_valid = 1'b0;
    next_rob   = next_rob + 1'b1;
  endtask

  task automatic push_random_uop();
    logic [3:0]  op;
    logic [63:0] vs1;
    logic [63:0] vs2;
    logic [7:0]  v0;
    logic        vm;
    op  = 4'(rand_bits(4) % 11);
    vs2 = rand_bits(64);
    vs1 = make_vs1(vs2);
    v0  = 8'(rand_bits(8));
    vm  = 1'(rand_bits(1));
    push_uop(op, vs1, vs2, v0, vm);
  endtask

  // push and result transfers of one edge, pre-edge values of both sides
  always @(posedge clk) begin : scoreboard
    logic        push_fire;
    logic        out_fire;
    logic [63:0] exp_vd;
    logic [3:0]  exp_rob;
    string       name;
    push_fire = rst_n && push_valid && push_ready;
    out_fire  = rst_n && result_valid && result_ready;
    in_flight <= in_flight + (push_fire ? 1 : 0) - (out_fire ? 1 : 0);
    if (push_fire) begin
      exp_vd_q.push_back(ref_vd(push_op, push_vs1, push_vs2, push_v0, push_vm));
      exp_rob_q.push_back(push_rob_idx);
      exp_name_q.push_back({phase, "/", op_class(push_op)});
      push_count <= push_count + 1;
    end
    if (out_fire) begin
      if (exp_vd_q.size() == 0) begin
        fail_run("a result came out with no uop outstanding");
      end else begin
        exp_vd  = exp_vd_q.pop_front();
        exp_rob = exp_rob_q.pop_front();
        name    = exp_name_q.pop_front();
        assert ({exp_rob, exp_vd} == {result_rob_idx, result_vd.bits})
          else report_mismatch(name, exp_vd, result_vd.bits, exp_rob, result_rob_idx);
      end
    end
  end

  // reset state and idle push side
  assert property (@(posedge clk) !rst_n |-> !result_valid)
    else fail_run("result_valid high during reset");
  assert property (@(posedge clk) (push_count == 0) |-> (push_ready && !result_valid))
    else fail_run("push_ready low or result_valid high before the first push");

  // occupancy against the system capacity
  assert property (@(posedge clk) disable iff (!rst_n) (in_flight < 4) |-> push_ready)
    else fail_run("push_ready low with fewer than four uops in flight");
  assert property (@(posedge clk) disable iff (!rst_n) (in_flight >= SYS_CAP) |-> !push_ready)
    else fail_run("push_ready high with the whole system full");

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == CYCLE_LIMIT)
      fail_run("timeout, the results did not drain within the cycle limit");
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    push_valid   = 1'b0;
    push_op      = '0;
    push_vs1     = '0;
    push_vs2     = '0;
    push_v0      = '0;
    push_vm      = 1'b0;
    push_rob_idx = '0;
    result_ready = 1'b1;
    lfsr_state   = 16'd8;
    next_rob     = '0;
    random_ready = 1'b0;
    phase        = "reset";
    in_flight    = 0;
    push_count   = 0;
    cycle_count  = 0;

    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    // single uop into an idle system, result four edges after the push
    phase = "latency";
    push_uop(`PMTRDT_OP_CMP_LTU, 64'h0102030405060708, 64'h0807060504030201, 8'h00, 1'b1);
    for (int i = 0; i < 4; i++) begin
      assert (!result_valid) else fail_run("result_valid rose before four cycles");
      @(negedge clk);
    end
    assert (result_valid) else fail_run("result_valid missing four cycles after the push");
    @(negedge clk);

    // every op, unmasked, none active, all active, three random masks
    phase = "directed";
    for (int op = 0; op <= 10; op++) begin
      for (int v = 0; v < 6; v++) begin
        logic [63:0] vs1;
        logic [63:0] vs2;
        vs2 = rand_bits(64);
        vs1 = make_vs1(vs2);
        case (v)
          0:       push_uop(4'(op), vs1, vs2, 8'(rand_bits(8)), 1'b1);
          1:       push_uop(4'(op), vs1, vs2, 8'h00, 1'b0);
          2:       push_uop(4'(op), vs1, vs2, 8'hff, 1'b0);
          default: push_uop(4'(op), vs1, vs2, 8'(rand_bits(8)), 1'b0);
        endcase
      end
    end

    // continuous pushes against a random result_ready
    phase        = "backpressure";
    random_ready = 1'b1;
    repeat (60) push_random_uop();
    random_ready = 1'b0;
    result_ready = 1'b1;
    while (in_flight != 0) @(negedge clk);

    // output held, fill until the queue refuses
    phase        = "fill";
    result_ready = 1'b0;
    while (push_ready) push_random_uop();
    assert (in_flight == SYS_CAP)
      else fail_run("push_ready dropped before four uops waited behind a held output");
    repeat (5) @(negedge clk);
    result_ready = 1'b1;

    while (in_flight != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    if (exp_vd_q.size() == 0 && !result_valid) begin
      $display("All tests passed!");
      $finish;
    end else begin
      fail_run("results still pending at the end of the run");
    end
  end

endmodule

// File: hdl/pmtrdt_top.sv
`timescale 1ns/1ps
`include "pmtrdt_defs.svh"

module pmtrdt_top import pmtrdt_pkg::*;
(
  clk,
  rst_n,

  push_valid,
  push_ready,
  push_op,
  push_vs1,
  push_vs2,
  push_v0,
  push_vm,
  push_rob_idx,

  result_valid,
  result_ready,
  result_vd,
  result_rob_idx
);
  input  logic                            clk;
  input  logic                            rst_n;

  // uop dispatch
  input  logic                            push_valid;
  output logic                            push_ready;
  input  logic [`PMTRDT_OP_W-1:0]         push_op;
  input  logic [`PMTRDT_VLEN-1:0]         push_vs1;
  input  logic [`PMTRDT_VLEN-1:0]         push_vs2;
  input  logic [`PMTRDT_NUM_ELEM-1:0]     push_v0;
  input  logic                            push_vm;
  input  logic [`PMTRDT_ROB_IDX_W-1:0]    push_rob_idx;

  // ROB writeback
  output logic                            result_valid;
  input  logic                            result_ready;
  output pmtrdt_vd_u                      result_vd;
  output logic [`PMTRDT_ROB_IDX_W-1:0]    result_rob_idx;

  // queue head to unit
  logic                           uop_valid;
  logic                           uop_ready;
  logic [`PMTRDT_OP_W-1:0]        uop_op;
  logic [`PMTRDT_VLEN-1:0]        uop_vs1;
  logic [`PMTRDT_VLEN-1:0]        uop_vs2;
  logic [`PMTRDT_NUM_ELEM-1:0]    uop_v0;
  logic                           uop_vm;
  logic [`PMTRDT_ROB_IDX_W-1:0]   uop_rob_idx;

  // unit to ROB port
  logic                           res_valid;
  logic                           res_ready;
  pmtrdt_vd_u                     res_vd;
  logic [`PMTRDT_ROB_IDX_W-1:0]   res_rob_idx;

  // reservation queue
  pmtrdt_uop_queue u_uop_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (push_valid),
    .push_ready   (push_ready),
    .push_op      (push_op),
    .push_vs1     (push_vs1),
    .push_vs2     (push_vs2),
    .push_v0      (push_v0),
    .push_vm      (push_vm),
    .push_rob_idx (push_rob_idx),
    .uop_valid    (uop_valid),
    .uop_ready    (uop_ready),
    .uop_op       (uop_op),
    .uop_vs1      (uop_vs1),
    .uop_vs2      (uop_vs2),
    .uop_v0       (uop_v0),
    .uop_vm       (uop_vm),
    .uop_rob_idx  (uop_rob_idx)
  );

  // compare, reduction and compress pipeline
  pmtrdt_unit u_pmtrdt_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .uop_valid    (uop_valid),
    .uop_ready    (uop_ready),
    .uop_op       (uop_op),
    .uop_vs1      (uop_vs1),
    .uop_vs2      (uop_vs2),
    .uop_v0       (uop_v0),
    .uop_vm       (uop_vm),
    .uop_rob_idx  (uop_rob_idx),
    .res_valid    (res_valid),
    .res_ready    (res_ready),
    .res_vd       (res_vd),
    .res_rob_idx  (res_rob_idx)
  );

  // result slice with skid entry
  pmtrdt_rob_port u_rob_port (
    .clk            (clk),
    .rst_n          (rst_n),
    .res_valid      (res_valid),
    .res_ready      (res_ready),
    .res_vd         (res_vd),
    .res_rob_idx    (res_rob_idx),
    .result_valid   (result_valid),
    .result_ready   (result_ready),
    .result_vd      (result_vd),
    .result_rob_idx (result_rob_idx)
  );

endmodule

// File: hdl/pmtrdt_rob_port.sv
`timescale 1ns/1ps
`include "pmtrdt_defs.svh"

module pmtrdt_rob_port import pmtrdt_pkg::*;
(
  clk,
  rst_n,

  res_valid,
  res_ready,
  res_vd,
  res_rob_idx,

  result_valid,
  result_ready,
  result_vd,
  result_rob_idx
);
  input  logic                            clk;
  input  logic                            rst_n;

  // from the unit
  input  logic                            res_valid;
  output logic                            res_ready;
  input  pmtrdt_vd_u                      res_vd;
  input  logic [`PMTRDT_ROB_IDX_W-1:0]    res_rob_idx;

  // toward the ROB
  output logic                            result_valid;
  input  logic                            result_ready;
  output pmtrdt_vd_u                      result_vd;
  output logic [`PMTRDT_ROB_IDX_W-1:0]    result_rob_idx;

  // skid entry
  logic                           skid_valid;
  pmtrdt_vd_u                     skid_vd;
  logic [`PMTRDT_ROB_IDX_W-1:0]   skid_rob_idx;

  logic                           res_fire;
  logic                           out_free;

  // ready comes straight from a flop
  assign res_ready = ~skid_valid;
  assign res_fire  = res_valid & res_ready;
  assign out_free  = ~result_valid | result_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid   <= 1'b0;
      result_vd      <= '0;
      result_rob_idx <= '0;
      skid_valid     <= 1'b0;
      skid_vd        <= '0;
      skid_rob_idx   <= '0;
    end else if (out_free) begin
      // older skid entry goes out before any new result
      if (skid_valid) begin
        result_valid   <= 1'b1;
        result_vd      <= skid_vd;
        result_rob_idx <= skid_rob_idx;
        skid_valid     <= 1'b0;
      end else if (res_fire) begin
        result_valid   <= 1'b1;
        result_vd      <= res_vd;
        result_rob_idx <= res_rob_idx;
      end else begin
        result_valid <= 1'b0;
      end
    end else if (res_fire) begin
      // main register stalled, park the incoming result
      skid_valid   <= 1'b1;
      skid_vd      <= res_vd;
      skid_rob_idx <= res_rob_idx;
    end
  end

endmodule

// File: hdl/pmtrdt_unit.sv
`timescale 1ns/1ps
`include "pmtrdt_defs.svh"

module pmtrdt_unit import pmtrdt_pkg::*;
(
  clk,
  rst_n,

  uop_valid,
  uop_ready,
  uop_op,
  uop_vs1,
  uop_vs2,
  uop_v0,
  uop_vm,
  uop_rob_idx,

  res_valid,
  res_ready,
  res_vd,
  res_rob_idx
);
  input  logic                            clk;
  input  logic                            rst_n;

  // uop from the reservation queue
  input  logic                            uop_valid;
  output logic                            uop_ready;
  input  logic [`PMTRDT_OP_W-1:0]         uop_op;
  input  logic [`PMTRDT_VLEN-1:0]         uop_vs1;
  input  logic [`PMTRDT_VLEN-1:0]         uop_vs2;
  input  logic [`PMTRDT_NUM_ELEM-1:0]     uop_v0;
  input  logic                            uop_vm;
  input  logic [`PMTRDT_ROB_IDX_W-1:0]    uop_rob_idx;

  // result toward the ROB port
  output logic                            res_valid;
  input  logic                            res_ready;
  output pmtrdt_vd_u                      res_vd;
  output logic [`PMTRDT_ROB_IDX_W-1:0]    res_rob_idx;

  localparam int NE    = `PMTRDT_NUM_ELEM;
  localparam int SEW   = `PMTRDT_SEW;
  localparam int IDX_W = $clog2(NE);

  // accepted uop, input of stage 1
  logic                           s0_valid;
  logic [`PMTRDT_OP_W-1:0]        s0_op;
  logic [`PMTRDT_VLEN-1:0]        s0_vs1;
  logic [`PMTRDT_VLEN-1:0]        s0_vs2;
  logic [NE-1:0]                  s0_v0;
  logic                           s0_vm;
  logic [`PMTRDT_ROB_IDX_W-1:0]   s0_rob_idx;

  // stage 1 results
  logic [NE-1:0]                  s1_act_nxt;
  logic [NE-1:0]                  s1_cmp_nxt;
  logic [`PMTRDT_VLEN-1:0]        s1_elem_nxt;
  logic [NE-1:0][IDX_W-1:0]       s1_prefix_nxt;

  // stage 1 register, input of stage 2
  logic                           s1_valid;
  logic [`PMTRDT_OP_W-1:0]        s1_op;
  logic [SEW-1:0]                 s1_seed;
  logic [NE-1:0]                  s1_act;
  logic [NE-1:0]                  s1_cmp;
  logic [`PMTRDT_VLEN-1:0]        s1_elem;
  logic [NE-1:0][IDX_W-1:0]       s1_prefix;
  logic [`PMTRDT_ROB_IDX_W-1:0]   s1_rob_idx;

  // stage 2 result before the output register
  pmtrdt_vd_u                     s2_vd;

  logic                           res_free;
  logic                           s1_free;
  logic                           s0_free;

  // a slot can load when empty or when its occupant moves on
  assign res_free  = ~res_valid | res_ready;
  assign s1_free   = ~s1_valid | res_free;
  assign s0_free   = ~s0_valid | s1_free;
  assign uop_ready = s0_free;

  // one reduction step on two elements
  function automatic logic [SEW-1:0] red_step(
    input logic [`PMTRDT_OP_W-1:0] op,
    input logic [SEW-1:0]          a,
    input logic [SEW-1:0]          b
  );
    case (op)
      `PMTRDT_OP_RED_SUM:  red_step = a + b;
      `PMTRDT_OP_RED_MAXU: red_step = (a > b) ? a : b;
      `PMTRDT_OP_RED_MINU: red_step = (a < b) ? a : b;
      `PMTRDT_OP_RED_AND:  red_step = a & b;
      `PMTRDT_OP_RED_OR:   red_step = a | b;
      `PMTRDT_OP_RED_XOR:  red_step = a ^ b;
      default:             red_step = a;
    endcase
  endfunction

  // accept register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s0_valid   <= 1'b0;
      s0_op      <= '0;
      s0_vs1     <= '0;
      s0_vs2     <= '0;
      s0_v0      <= '0;
      s0_vm      <= 1'b0;
      s0_rob_idx <= '0;
    end else if (s0_free) begin
      s0_valid <= uop_valid;
      if (uop_valid) begin
        s0_op      <= uop_op;
        s0_vs1     <= uop_vs1;
        s0_vs2     <= uop_vs2;
        s0_v0      <= uop_v0;
        s0_vm      <= uop_vm;
        s0_rob_idx <= uop_rob_idx;
      end
    end
  end

  // stage 1: active mask, compare bits, masked elements, prefix counts
  always_comb begin : stage1_comb
    logic [SEW-1:0]  a;
    logic [SEW-1:0]  b;
    logic [SEW-1:0]  ident;
    logic [IDX_W:0]  cnt;
    // vm set means unmasked
    s1_act_nxt = s0_vm ? '1 : s0_v0;
    // and/minu start from all ones, everything else from zero
    ident = ((s0_op == `PMTRDT_OP_RED_AND) || (s0_op == `PMTRDT_OP_RED_MINU)) ? '1 : '0;
    cnt   = '0;
    for (int i = 0; i < NE; i++) begin
      a = s0_vs2[i*SEW +: SEW];
      b = s0_vs1[i*SEW +: SEW];
      case (s0_op)
        `PMTRDT_OP_CMP_EQ:  s1_cmp_nxt[i] = (a == b);
        `PMTRDT_OP_CMP_NE:  s1_cmp_nxt[i] = (a != b);
        `PMTRDT_OP_CMP_LTU: s1_cmp_nxt[i] = (a < b);
        `PMTRDT_OP_CMP_LT:  s1_cmp_nxt[i] = ($signed(a) < $signed(b));
        default:            s1_cmp_nxt[i] = 1'b0;
      endcase
      // inactive mask bits read as zero
      s1_cmp_nxt[i] = s1_cmp_nxt[i] & s1_act_nxt[i];
      s1_elem_nxt[i*SEW +: SEW] = s1_act_nxt[i] ? a : ident;
      // slot index = active elements below this one
      s1_prefix_nxt[i] = cnt[IDX_W-1:0];
      cnt = cnt + {{IDX_W{1'b0}}, s1_act_nxt[i]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid   <= 1'b0;
      s1_op      <= '0;
      s1_seed    <= '0;
      s1_act     <= '0;
      s1_cmp     <= '0;
      s1_elem    <= '0;
      s1_prefix  <= '0;
      s1_rob_idx <= '0;
    end else if (s1_free) begin
      s1_valid <= s0_valid;
      if (s0_valid) begin
        s1_op      <= s0_op;
        // scalar seed is vs1 element 0
        s1_seed    <= s0_vs1[SEW-1:0];
        s1_act     <= s1_act_nxt;
        s1_cmp     <= s1_cmp_nxt;
        s1_elem    <= s1_elem_nxt;
        s1_prefix  <= s1_prefix_nxt;
        s1_rob_idx <= s0_rob_idx;
      end
    end
  end

  // stage 2: fold, flat mask or scatter
  always_comb begin : stage2_comb
    logic [SEW-1:0] acc;
    s2_vd.bits = '0;
    // inactive elements hold the identity so the fold runs over all eight
    acc = s1_seed;
    for (int i = 0; i < NE; i++)
      acc = red_step(s1_op, acc, s1_elem[i*SEW +: SEW]);
    case (s1_op)
      `PMTRDT_OP_CMP_EQ,
      `PMTRDT_OP_CMP_NE,
      `PMTRDT_OP_CMP_LTU,
      `PMTRDT_OP_CMP_LT:
        s2_vd.bits[NE-1:0] = s1_cmp;
      `PMTRDT_OP_RED_SUM,
      `PMTRDT_OP_RED_MAXU,
      `PMTRDT_OP_RED_MINU,
      `PMTRDT_OP_RED_AND,
      `PMTRDT_OP_RED_OR,
      `PMTRDT_OP_RED_XOR:
        s2_vd.elem[0] = acc;
      `PMTRDT_OP_COMPRESS: begin
        // tail stays zero
        for (int i = 0; i < NE; i++)
          if (s1_act[i])
            s2_vd.elem[s1_prefix[i]] = s1_elem[i*SEW +: SEW];
      end
      default: s2_vd.bits = '0;
    endcase
  end

  // output register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid   <= 1'b0;
      res_vd      <= '0;
      res_rob_idx <= '0;
    end else if (res_free) begin
      res_valid <= s1_valid;
      if (s1_valid) begin
        res_vd      <= s2_vd;
        res_rob_idx <= s1_rob_idx;
      end
    end
  end

endmodule

// File: hdl/pmtrdt_uop_queue.sv
`timescale 1ns/1ps
`include "pmtrdt_defs.svh"

module pmtrdt_uop_queue
(
  clk,
  rst_n,

  push_valid,
  push_ready,
  push_op,
  push_vs1,
  push_vs2,
  push_v0,
  push_vm,
  push_rob_idx,

  uop_valid,
  uop_ready,
  uop_op,
  uop_vs1,
  uop_vs2,
  uop_v0,
  uop_vm,
  uop_rob_idx
);
  input  logic                            clk;
  input  logic                            rst_n;

  // dispatch side
  input  logic                            push_valid;
  output logic                            push_ready;
  input  logic [`PMTRDT_OP_W-1:0]         push_op;
  input  logic [`PMTRDT_VLEN-1:0]         push_vs1;
  input  logic [`PMTRDT_VLEN-1:0]         push_vs2;
  input  logic [`PMTRDT_NUM_ELEM-1:0]     push_v0;
  input  logic                            push_vm;
  input  logic [`PMTRDT_ROB_IDX_W-1:0]    push_rob_idx;

  // head of queue toward the unit
  output logic                            uop_valid;
  input  logic                            uop_ready;
  output logic [`PMTRDT_OP_W-1:0]         uop_op;
  output logic [`PMTRDT_VLEN-1:0]         uop_vs1;
  output logic [`PMTRDT_VLEN-1:0]         uop_vs2;
  output logic [`PMTRDT_NUM_ELEM-1:0]     uop_v0;
  output logic                            uop_vm;
  output logic [`PMTRDT_ROB_IDX_W-1:0]    uop_rob_idx;

  localparam int DEPTH = `PMTRDT_RS_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int LAST  = DEPTH - 1;

  logic [PTR_W-1:0]                 wr_ptr;
  logic [PTR_W-1:0]                 rd_ptr;
  logic [PTR_W:0]                   count;
  logic                             full;
  logic                             push_fire;
  logic                             pop_fire;

  // entry storage, one array per uop field
  logic [`PMTRDT_OP_W-1:0]          op_mem  [DEPTH];
  logic [`PMTRDT_VLEN-1:0]          vs1_mem [DEPTH];
  logic [`PMTRDT_VLEN-1:0]          vs2_mem [DEPTH];
  logic [`PMTRDT_NUM_ELEM-1:0]      v0_mem  [DEPTH];
  logic                             vm_mem  [DEPTH];
  logic [`PMTRDT_ROB_IDX_W-1:0]     rob_mem [DEPTH];

  assign full       = (count == DEPTH[PTR_W:0]);
  // not empty
  assign uop_valid  = (count != '0);
  // full queue still takes a push when the head leaves this cycle
  assign push_ready = ~full | uop_ready;
  assign push_fire  = push_valid & push_ready;
  assign pop_fire   = uop_valid & uop_ready;

  // head entry presented without a register stage
  assign uop_op      = op_mem[rd_ptr];
  assign uop_vs1     = vs1_mem[rd_ptr];
  assign uop_vs2     = vs2_mem[rd_ptr];
  assign uop_v0      = v0_mem[rd_ptr];
  assign uop_vm      = vm_mem[rd_ptr];
  assign uop_rob_idx = rob_mem[rd_ptr];

  // wrap at the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == LAST[PTR_W-1:0]) ? '0 : ptr + 1'b1;
  endfunction

  // pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop_fire)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // write port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        op_mem[i]  <= '0;
        vs1_mem[i] <= '0;
        vs2_mem[i] <= '0;
        v0_mem[i]  <= '0;
        vm_mem[i]  <= 1'b0;
        rob_mem[i] <= '0;
      end
    end else if (push_fire) begin
      op_mem[wr_ptr]  <= push_op;
      vs1_mem[wr_ptr] <= push_vs1;
      vs2_mem[wr_ptr] <= push_vs2;
      v0_mem[wr_ptr]  <= push_v0;
      vm_mem[wr_ptr]  <= push_vm;
      rob_mem[wr_ptr] <= push_rob_idx;
    end
  end

endmodule

// File: hdl/pmtrdt_pkg.sv
`include "pmtrdt_defs.svh"

package pmtrdt_pkg;

  // destination word of one uop
  // compares read it as a flat vector, mask sits in the low bits
  // reductions and compress read it as eight elements
  typedef union packed {
    // flat view
    logic [`PMTRDT_VLEN-1:0]                      bits;
    // element view, elem[0] is the lowest byte
    logic [`PMTRDT_NUM_ELEM-1:0][`PMTRDT_SEW-1:0] elem;
  } pmtrdt_vd_u;

endpackage

// File: hdl/pmtrdt_defs.svh
`ifndef PMTRDT_DEFS_SVH
`define PMTRDT_DEFS_SVH

// vector register geometry, SEW 8 and LMUL 1 only
`define PMTRDT_VLEN       64
`define PMTRDT_SEW        8
`define PMTRDT_NUM_ELEM   8

// reservation queue entries
`define PMTRDT_RS_DEPTH   4

// uop tag and opcode widths
`define PMTRDT_ROB_IDX_W  4
`define PMTRDT_OP_W       4

// compares, mask result in low bits of vd
`define PMTRDT_OP_CMP_EQ    4'd0
`define PMTRDT_OP_CMP_NE    4'd1
`define PMTRDT_OP_CMP_LTU   4'd2
`define PMTRDT_OP_CMP_LT    4'd3

// reductions, seed from vs1 element 0
`define PMTRDT_OP_RED_SUM   4'd4
`define PMTRDT_OP_RED_MAXU  4'd5
`define PMTRDT_OP_RED_MINU  4'd6
`define PMTRDT_OP_RED_AND   4'd7
`define PMTRDT_OP_RED_OR    4'd8
`define PMTRDT_OP_RED_XOR   4'd9

// permutation
`define PMTRDT_OP_COMPRESS  4'd10

`endif
